/* dv/hazard_unit_asserts.sv */
`default_nettype none

`include "trap_config.svh"

module hazard_unit_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic [`TRAP_REG_W-1:0]  id_rs1,
    input logic [`TRAP_REG_W-1:0]  id_rs2,
    input logic [`TRAP_REG_W-1:0]  ex_rd,
    input logic                    ex_mem_read,
    input logic                    branch_taken,
    input logic                    csr_redirect,
    input logic                    jump_taken,
    input logic                    imem_stall,
    input logic                    dmem_stall,
    input logic                    pc_misaligned,
    input logic                    imem_inst_fault,
    input logic [`TRAP_XLEN-1:0]   imem_fault_va,
    input logic                    illegal_inst,
    input logic [`TRAP_XLEN-1:0]   id_inst,
    input logic                    dmem_inst_fault,
    input logic                    dmem_load_fault,
    input logic                    dmem_store_fault,
    input trap_pkg::decode_fault_t mem_fault,
    input trap_pkg::hazard_e       hazard_code,
    input trap_pkg::trap_e         trap_cause,
    input logic [`TRAP_XLEN-1:0]   trap_inst,
    input logic [`TRAP_XLEN-1:0]   trap_va
);

    int unsigned       fail_count = 0;
    trap_pkg::hazard_e exp_code;
    logic              dmem_any;
    logic              carried_any;

    assign dmem_any    = dmem_inst_fault | dmem_load_fault | dmem_store_fault;
    assign carried_any = mem_fault.fetch.pc_misaligned | mem_fault.fetch.inst_page_fault |
                         mem_fault.illegal_inst;

    // Redirect, memory stall, load-use on a non-zero rd, jump
    assign exp_code =
        (branch_taken || csr_redirect || trap_cause != trap_pkg::TRAP_NONE) ?
            trap_pkg::HAZ_FLUSH_ALL :
        (imem_stall || dmem_stall) ? trap_pkg::HAZ_STALL_MEM :
        (ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2)) ?
            trap_pkg::HAZ_STALL_EARLY :
        jump_taken ? trap_pkg::HAZ_FLUSH_EARLY : trap_pkg::HAZ_NONE;

    hazard_priority: assert property (@(posedge clk) hazard_code == exp_code)
        else begin
            fail_count++;
            $error("ERROR hazard_code got %h expected %h", $sampled(hazard_code),
                   $sampled(exp_code));
        end

    reset_no_trap: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> trap_cause == trap_pkg::TRAP_NONE)
        else begin
            fail_count++;
            $error("ERROR trap_cause got %h expected %h", $sampled(trap_cause),
                   trap_pkg::TRAP_NONE);
        end

    ////////////////////////////////////////////////////////////////////////////
    // Carried faults
    ////////////////////////////////////////////////////////////////////////////

    fetch_fault_at_mem: assert property (@(posedge clk) disable iff (!rst_n)
        (($past(pc_misaligned, 3) || $past(imem_inst_fault, 3)) &&
         $past(hazard_code, 3) == trap_pkg::HAZ_NONE &&
         $past(hazard_code, 2) == trap_pkg::HAZ_NONE &&
         $past(hazard_code, 1) == trap_pkg::HAZ_NONE) |->
        trap_cause == ($past(pc_misaligned, 3) ? trap_pkg::TRAP_MISALIGNED_PC :
                       trap_pkg::TRAP_INST_PAGE_FAULT) &&
        trap_va == $past(imem_fault_va, 3))
        else begin
            fail_count++;
            $error("ERROR trap_cause %h trap_va got %h expected %h", $sampled(trap_cause),
                   $sampled(trap_va), $past(imem_fault_va, 3));
        end

    // Fetch flags riding with the same instruction may still win
    illegal_at_mem: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(illegal_inst, 2) && $past(hazard_code, 3) == trap_pkg::HAZ_NONE &&
         $past(hazard_code, 2) == trap_pkg::HAZ_NONE &&
         $past(hazard_code, 1) == trap_pkg::HAZ_NONE) |->
        trap_inst == $past(id_inst, 2) &&
        trap_cause == ($past(pc_misaligned, 3) ? trap_pkg::TRAP_MISALIGNED_PC :
                       $past(imem_inst_fault, 3) ? trap_pkg::TRAP_INST_PAGE_FAULT :
                       trap_pkg::TRAP_ILLEGAL_INST))
        else begin
            fail_count++;
            $error("ERROR trap_cause %h trap_inst got %h expected %h", $sampled(trap_cause),
                   $sampled(trap_inst), $past(id_inst, 2));
        end

    stall_keeps_trap: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(hazard_code) == trap_pkg::HAZ_STALL_MEM && !dmem_any) |->
        trap_cause == $past(trap_cause) && trap_va == $past(trap_va))
        else begin
            fail_count++;
            $error("ERROR trap_cause got %h expected %h trap_va got %h expected %h",
                   $sampled(trap_cause), $past(trap_cause), $sampled(trap_va),
                   $past(trap_va));
        end

    trap_drains_pipe: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(trap_cause) != trap_pkg::TRAP_NONE && !dmem_any) |->
        trap_cause == trap_pkg::TRAP_NONE)
        else begin
            fail_count++;
            $error("ERROR trap_cause got %h expected %h", $sampled(trap_cause),
                   trap_pkg::TRAP_NONE);
        end

    data_fault_cause: assert property (@(posedge clk) disable iff (!rst_n)
        (!carried_any && dmem_any) |->
        trap_cause == (dmem_inst_fault ? trap_pkg::TRAP_INST_PAGE_FAULT :
                       dmem_load_fault ? trap_pkg::TRAP_LOAD_PAGE_FAULT :
                       trap_pkg::TRAP_STORE_PAGE_FAULT))
        else begin
            fail_count++;
            $error("ERROR trap_cause got %h with dmem faults %h", $sampled(trap_cause),
                   $sampled({dmem_inst_fault, dmem_load_fault, dmem_store_fault}));
        end

endmodule

`default_nettype wire

/* dv/hazard_unit_tb.sv */
`default_nettype none

`include "trap_config.svh"

module hazard_unit_tb;

    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_CYCLES = 400;
    // Reset, about 40 directed cycles and the random phase, with margin
    localparam int MAX_CYCLES    = 600;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [`TRAP_REG_W-1:0] id_rs1;
    logic [`TRAP_REG_W-1:0] id_rs2;
    logic [`TRAP_REG_W-1:0] ex_rd;
    logic                   ex_mem_read;
    logic                   branch_taken;
    logic                   csr_redirect;
    logic                   jump_taken;
    logic                   imem_stall;
    logic                   dmem_stall;
    logic                   pc_misaligned;
    logic                   imem_inst_fault;
    logic [`TRAP_XLEN-1:0]  imem_fault_va;
    logic                   illegal_inst;
    logic [`TRAP_XLEN-1:0]  id_inst;
    logic                   dmem_inst_fault;
    logic                   dmem_load_fault;
    logic                   dmem_store_fault;
    trap_pkg::hazard_e      hazard_code;
    trap_pkg::trap_e        trap_cause;
    logic [`TRAP_XLEN-1:0]  trap_inst;
    logic [`TRAP_XLEN-1:0]  trap_va;
    integer                 seed;
    int                     cycle_count = 0;

    hazard_unit i_hazard_unit (.*);

    bind hazard_unit hazard_unit_asserts i_asserts (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Simulation failed");
            $fatal(1, "Timeout after %0d cycles", cycle_count);
        end
    end

    always @(negedge clk) begin
        if (i_hazard_unit.i_asserts.fail_count != 0) begin
            $display("Simulation failed");
            $fatal(1, "Assertion check failed");
        end
    end

    // Four registers including x0, so collisions are frequent
    function automatic logic [`TRAP_REG_W-1:0] pick_reg(input int r);
        logic [`TRAP_REG_W-1:0] idx;
        idx      = '0;
        idx[1:0] = r[1:0];
        return idx;
    endfunction

    function automatic logic one_in(input int r, input int mask);
        return (r & mask) == 0;
    endfunction

    task automatic clear_inputs();
        {id_rs1, id_rs2, ex_rd, ex_mem_read, branch_taken, csr_redirect, jump_taken,
         imem_stall, dmem_stall, pc_misaligned, imem_inst_fault, imem_fault_va,
         illegal_inst, id_inst, dmem_inst_fault, dmem_load_fault, dmem_store_fault} = '0;
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    task automatic random_cycle();
        @(negedge clk);
        id_rs1           = pick_reg($random(seed));
        id_rs2           = pick_reg($random(seed));
        ex_rd            = pick_reg($random(seed));
        ex_mem_read      = one_in($random(seed), 1);
        branch_taken     = one_in($random(seed), 15);
        csr_redirect     = one_in($random(seed), 31);
        jump_taken       = one_in($random(seed), 7);
        imem_stall       = one_in($random(seed), 7);
        dmem_stall       = one_in($random(seed), 7);
        pc_misaligned    = one_in($random(seed), 31);
        imem_inst_fault  = one_in($random(seed), 31);
        imem_fault_va    = $random(seed);
        illegal_inst     = one_in($random(seed), 31);
        id_inst          = $random(seed);
        dmem_inst_fault  = one_in($random(seed), 63);
        dmem_load_fault  = one_in($random(seed), 31);
        dmem_store_fault = one_in($random(seed), 31);
    endtask

    initial begin
        seed  = 32'h76091d4c;
        rst_n = 1'b0;
        clear_inputs();
        quiet_cycles(RESET_CYCLES);
        rst_n = 1'b1;
        quiet_cycles(2);

        // Fetch faults, the second meets a load fault at MEM
        pc_misaligned = 1'b1;
        imem_fault_va = 32'h0000_1002;
        quiet_cycles(5);
        imem_inst_fault = 1'b1;
        imem_fault_va   = 32'h8000_3000;
        quiet_cycles(3);
        dmem_load_fault = 1'b1;
        quiet_cycles(2);
        illegal_inst = 1'b1;
        id_inst      = 32'hdead_0073;
        quiet_cycles(4);

        // Data side only
        dmem_store_fault = 1'b1;
        quiet_cycles(1);
        dmem_load_fault  = 1'b1;
        dmem_store_fault = 1'b1;
        quiet_cycles(2);

        // Fault frozen in EX by memory stalls
        imem_inst_fault = 1'b1;
        imem_fault_va   = 32'h0000_4ffc;
        quiet_cycles(2);
        dmem_stall = 1'b1;
        quiet_cycles(1);
        imem_stall = 1'b1;
        quiet_cycles(5);

        // Load-use on x3, then on x0, then a jump
        ex_mem_read = 1'b1;
        ex_rd       = pick_reg(3);
        id_rs2      = pick_reg(3);
        quiet_cycles(1);
        ex_mem_read = 1'b1;
        quiet_cycles(1);
        jump_taken = 1'b1;
        quiet_cycles(2);

        repeat (RANDOM_CYCLES) random_cycle();
        quiet_cycles(4);

        if (i_hazard_unit.i_asserts.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "Assertion checks failed");
        end
    end

endmodule

`default_nettype wire

/* logic/hazard_detect.sv */
`default_nettype none

`include "trap_config.svh"

module hazard_detect (
    input  logic [`TRAP_REG_W-1:0] id_rs1,
    input  logic [`TRAP_REG_W-1:0] id_rs2,
    input  logic [`TRAP_REG_W-1:0] ex_rd,
    input  logic                   ex_mem_read,
    input  logic                   branch_taken,
    input  logic                   csr_redirect,
    input  logic                   jump_taken,
    input  logic                   imem_stall,
    input  logic                   dmem_stall,
    input  trap_pkg::trap_e        trap_cause,
    output trap_pkg::hazard_e      hazard_code
);

    logic full_redirect;
    logic mem_stall;
    logic load_use;

    // Branch resolved in EX, CSR writes, or a trap taken at MEM
    assign full_redirect = branch_taken | csr_redirect |
                           (trap_cause != trap_pkg::TRAP_NONE);

    assign mem_stall = imem_stall | dmem_stall;

    // x0 is never a real dependence
    assign load_use = ex_mem_read && (ex_rd != '0) &&
                      ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    ////////////////////////////////////////////////////////////////////////////
    // Priority resolve
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (full_redirect) begin
            hazard_code = trap_pkg::HAZ_FLUSH_ALL;
        end else if (mem_stall) begin
            hazard_code = trap_pkg::HAZ_STALL_MEM;
        end else if (load_use) begin
            hazard_code = trap_pkg::HAZ_STALL_EARLY;
        end else if (jump_taken) begin
            hazard_code = trap_pkg::HAZ_FLUSH_EARLY;
        end else begin
            hazard_code = trap_pkg::HAZ_NONE;
        end
    end

endmodule

`default_nettype wire

/* logic/hazard_unit.sv */
`default_nettype none

`include "trap_config.svh"

module hazard_unit (
    input  logic                   clk,
    input  logic                   rst_n,

    // Load-use
    input  logic [`TRAP_REG_W-1:0] id_rs1,
    input  logic [`TRAP_REG_W-1:0] id_rs2,
    input  logic [`TRAP_REG_W-1:0] ex_rd,
    input  logic                   ex_mem_read,

    // Redirects
    input  logic                   branch_taken,
    input  logic                   csr_redirect,
    input  logic                   jump_taken,

    input  logic                   imem_stall,
    input  logic                   dmem_stall,

    // Fetch side faults
    input  logic                   pc_misaligned,
    input  logic                   imem_inst_fault,
    input  logic [`TRAP_XLEN-1:0]  imem_fault_va,

    // Decode
    input  logic                   illegal_inst,
    input  logic [`TRAP_XLEN-1:0]  id_inst,

    // Data side faults
    input  logic                   dmem_inst_fault,
    input  logic                   dmem_load_fault,
    input  logic                   dmem_store_fault,

    output trap_pkg::hazard_e      hazard_code,
    output trap_pkg::trap_e        trap_cause,
    output logic [`TRAP_XLEN-1:0]  trap_inst,
    output logic [`TRAP_XLEN-1:0]  trap_va
);

    trap_pkg::fetch_fault_t  if_fault;
    trap_pkg::fetch_fault_t  id_fault;
    trap_pkg::decode_fault_t ex_d;
    trap_pkg::decode_fault_t ex_fault;
    trap_pkg::decode_fault_t mem_fault;

    assign if_fault.pc_misaligned   = pc_misaligned;
    assign if_fault.inst_page_fault = imem_inst_fault;
    assign if_fault.fault_va        = imem_fault_va;

    // Fetch flags joined with the decode result
    assign ex_d.fetch        = id_fault;
    assign ex_d.illegal_inst = illegal_inst;
    assign ex_d.fault_inst   = id_inst;

    hazard_detect i_hazard_detect (
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .ex_rd        (ex_rd),
        .ex_mem_read  (ex_mem_read),
        .branch_taken (branch_taken),
        .csr_redirect (csr_redirect),
        .jump_taken   (jump_taken),
        .imem_stall   (imem_stall),
        .dmem_stall   (dmem_stall),
        .trap_cause   (trap_cause),
        .hazard_code  (hazard_code)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Fault pipeline IF -> ID -> EX -> MEM
    ////////////////////////////////////////////////////////////////////////////

    stage_reg #(
        .payload_t (trap_pkg::fetch_fault_t),
        .stage     (trap_pkg::STAGE_ID)
    ) i_stage_id (
        .clk         (clk),
        .rst_n       (rst_n),
        .hazard_code (hazard_code),
        .d           (if_fault),
        .q           (id_fault)
    );

    stage_reg #(
        .payload_t (trap_pkg::decode_fault_t),
        .stage     (trap_pkg::STAGE_EX)
    ) i_stage_ex (
        .clk         (clk),
        .rst_n       (rst_n),
        .hazard_code (hazard_code),
        .d           (ex_d),
        .q           (ex_fault)
    );

    stage_reg #(
        .payload_t (trap_pkg::decode_fault_t),
        .stage     (trap_pkg::STAGE_MEM)
    ) i_stage_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .hazard_code (hazard_code),
        .d           (ex_fault),
        .q           (mem_fault)
    );

    trap_select i_trap_select (
        .mem_fault        (mem_fault),
        .dmem_inst_fault  (dmem_inst_fault),
        .dmem_load_fault  (dmem_load_fault),
        .dmem_store_fault (dmem_store_fault),
        .trap_cause       (trap_cause),
        .trap_inst        (trap_inst),
        .trap_va          (trap_va)
    );

endmodule

`default_nettype wire

/* logic/stage_reg.sv */
`default_nettype none

module stage_reg #(
    parameter type             payload_t = logic,
    parameter trap_pkg::stage_e stage    = trap_pkg::STAGE_ID
) (
    input  logic              clk,
    input  logic              rst_n,
    input  trap_pkg::hazard_e hazard_code,
    input  payload_t          d,
    output payload_t          q
);

    logic clear;
    logic hold;

    // Per-stage reaction to the hazard code
    always_comb begin
        clear = 1'b0;
        hold  = 1'b0;
        case (hazard_code)
            trap_pkg::HAZ_FLUSH_ALL: clear = 1'b1;
            trap_pkg::HAZ_STALL_MEM: hold  = 1'b1;
            trap_pkg::HAZ_STALL_EARLY: begin
                // ID freezes, EX takes a bubble, MEM drains
                hold  = (stage == trap_pkg::STAGE_ID);
                clear = (stage == trap_pkg::STAGE_EX);
            end
            trap_pkg::HAZ_FLUSH_EARLY: clear = (stage == trap_pkg::STAGE_ID);
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* logic/trap_config.svh */
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// Address and instruction word width
`define TRAP_XLEN 32

// Register index width
`define TRAP_REG_W 5

`endif

/* logic/trap_pkg.sv */
`default_nettype none

`include "trap_config.svh"

package trap_pkg;

    // Hazard codes, in no particular priority
    typedef enum logic [2:0] {
        HAZ_NONE        = 3'd0,
        HAZ_FLUSH_EARLY = 3'd1,
        HAZ_STALL_EARLY = 3'd2,
        HAZ_STALL_MEM   = 3'd3,
        HAZ_FLUSH_ALL   = 3'd4
    } hazard_e;

    // mcause exception codes
    typedef enum logic [4:0] {
        TRAP_MISALIGNED_PC    = 5'd0,
        TRAP_ILLEGAL_INST     = 5'd2,
        TRAP_INST_PAGE_FAULT  = 5'd12,
        TRAP_LOAD_PAGE_FAULT  = 5'd13,
        TRAP_STORE_PAGE_FAULT = 5'd15,
        TRAP_NONE             = 5'h1f
    } trap_e;

    typedef enum logic [1:0] {
        STAGE_ID  = 2'd0,
        STAGE_EX  = 2'd1,
        STAGE_MEM = 2'd2
    } stage_e;

    // Faults known at fetch
    typedef struct packed {
        logic                  pc_misaligned;
        logic                  inst_page_fault;
        logic [`TRAP_XLEN-1:0] fault_va;
    } fetch_fault_t;

    // Fetch faults plus decode result
    typedef struct packed {
        fetch_fault_t          fetch;
        logic                  illegal_inst;
        logic [`TRAP_XLEN-1:0] fault_inst;
    } decode_fault_t;

endpackage

`default_nettype wire

/* logic/trap_select.sv */
`default_nettype none

`include "trap_config.svh"

module trap_select (
    input  trap_pkg::decode_fault_t mem_fault,
    input  logic                    dmem_inst_fault,
    input  logic                    dmem_load_fault,
    input  logic                    dmem_store_fault,
    output trap_pkg::trap_e         trap_cause,
    output logic [`TRAP_XLEN-1:0]   trap_inst,
    output logic [`TRAP_XLEN-1:0]   trap_va
);

    // Older faults carried from IF and ID win over data side
    always_comb begin
        if (mem_fault.fetch.pc_misaligned) begin
            trap_cause = trap_pkg::TRAP_MISALIGNED_PC;
        end else if (mem_fault.fetch.inst_page_fault) begin
            trap_cause = trap_pkg::TRAP_INST_PAGE_FAULT;
        end else if (mem_fault.illegal_inst) begin
            trap_cause = trap_pkg::TRAP_ILLEGAL_INST;
        end else if (dmem_inst_fault) begin
            trap_cause = trap_pkg::TRAP_INST_PAGE_FAULT;
        end else if (dmem_load_fault) begin
            trap_cause = trap_pkg::TRAP_LOAD_PAGE_FAULT;
        end else if (dmem_store_fault) begin
            trap_cause = trap_pkg::TRAP_STORE_PAGE_FAULT;
        end else begin
            trap_cause = trap_pkg::TRAP_NONE;
        end
    end

    // For mtval
    assign trap_inst = mem_fault.fault_inst;
    assign trap_va   = mem_fault.fetch.fault_va;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module hazard_unit_tb -f sim.f -o hazard_unit_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/hazard_unit_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

/* sim.f */
+incdir+logic
logic/trap_pkg.sv
logic/stage_reg.sv
logic/hazard_detect.sv
logic/trap_select.sv
logic/hazard_unit.sv
dv/hazard_unit_asserts.sv
dv/hazard_unit_tb.sv
